// File: hw/ps2_pkg.sv
package ps2_pkg;

    // Frame layout: start, 8 data, parity, stop
    localparam int FRAME_BITS = 11;
    localparam logic [3:0] LAST_BIT_IDX = 4'd10;  // Stop bit position

    // Stall counter, 2^17 clk cycles is about 1.3 ms at 100 MHz
    localparam int TIMEOUT_W = 17;

    // Prefix bytes
    localparam logic [7:0] SC_EXTEND = 8'hE0;
    localparam logic [7:0] SC_BREAK  = 8'hF0;

    // Modifier keys, right Ctrl and right Alt come after E0
    localparam logic [7:0] SC_LSHIFT = 8'h12;
    localparam logic [7:0] SC_RSHIFT = 8'h59;
    localparam logic [7:0] SC_CTRL   = 8'h14;
    localparam logic [7:0] SC_ALT    = 8'h11;

    // Lock keys, toggled on make only
    localparam logic [7:0] SC_CAPS   = 8'h58;
    localparam logic [7:0] SC_NUM    = 8'h77;
    localparam logic [7:0] SC_SCROLL = 8'h7E;

endpackage

// File: hw/ps2_key_if.sv
`timescale 1ns/1ps

// Delivered key and modifier levels, tracker to ASCII map
interface ps2_key_if;
    logic [7:0] code;        // Last non-prefix byte
    logic       code_ext;    // Code came after E0
    logic       code_break;  // Code came after F0
    logic       shift_on;    // Either Shift held
    logic       ctrl_on;     // Either Ctrl held
    logic       caps_on;
    logic       num_on;
    logic [7:0] ascii;       // Translation, back from the map

    modport tracker (
        output code, code_ext, code_break,
        output shift_on, ctrl_on, caps_on, num_on,
        input  ascii
    );

    modport map (
        input  code, code_ext, code_break,
        input  shift_on, ctrl_on, caps_on, num_on,
        output ascii
    );
endinterface

// File: hw/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       frame_valid,
    output logic       frame_err,
    output logic [7:0] frame_byte
);

    logic [2:0]            clk_sync;   // [0] first flop, [2] last
    logic [2:0]            data_sync;
    logic                  fall_edge;
    logic                  last_bit;
    logic [3:0]            bit_cnt;
    logic [TIMEOUT_W-1:0]  tmo_cnt;
    logic [FRAME_BITS-2:0] shreg;      // Start, data and parity
    logic [FRAME_BITS-1:0] frame_w;    // Full frame incl. live stop bit
    logic                  frame_ok;

    // Three flop synchronizers, idle lines read high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[1:0], ps2_data};
        end
    end

    assign fall_edge = !clk_sync[1] && clk_sync[2];
    assign last_bit  = fall_edge && (bit_cnt == LAST_BIT_IDX);

    // Stop bit taken straight from the synchronizer
    assign frame_w  = {data_sync[2], shreg};
    assign frame_ok = !frame_w[0]                      // Start bit low
                   && frame_w[LAST_BIT_IDX]            // Stop bit high
                   && (^frame_w[FRAME_BITS-2:1]);      // Odd parity

    // Bit counter and stall timeout
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            tmo_cnt <= '0;
        end else if (fall_edge) begin
            tmo_cnt <= '0;                             // Restart on every edge
            bit_cnt <= last_bit ? 4'd0 : bit_cnt + 4'd1;
        end else if (bit_cnt != 4'd0) begin
            tmo_cnt <= tmo_cnt + 1'b1;
            if (&tmo_cnt)
                bit_cnt <= '0;                         // Wrap, drop partial frame
        end
    end

    // Deserializer, one bit per falling edge
    always_ff @(posedge clk) begin
        if (fall_edge && !last_bit)
            shreg[bit_cnt] <= data_sync[2];
    end

    // Result strobes, one cycle after the stop bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid <= 1'b0;
            frame_err   <= 1'b0;
        end else begin
            frame_valid <= last_bit && frame_ok;
            frame_err   <= last_bit && !frame_ok;
        end
    end

    // Payload byte, held until the next frame ends
    always_ff @(posedge clk) begin
        if (last_bit)
            frame_byte <= frame_w[8:1];
    end

endmodule

// File: hw/ps2_key_tracker.sv
`timescale 1ns/1ps

module ps2_key_tracker
    import ps2_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        frame_valid,
    input  logic        frame_err,
    input  logic [7:0]  frame_byte,
    ps2_key_if.tracker  key,
    output logic [7:0]  scan_code,
    output logic        key_pressed,
    output logic        key_released,
    output logic        error,
    output logic        sft_active,
    output logic        ctr_active,
    output logic        alt_active
);

    logic ext_pend;            // E0 seen, waiting for code
    logic brk_pend;            // F0 seen, waiting for code
    logic code_ext;
    logic code_break;
    logic is_make;
    logic sft_l, sft_r;
    logic ctr_l, ctr_r;
    logic alt_l, alt_r;
    logic caps_on, num_on;

    assign is_make   = !brk_pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_pend     <= 1'b0;
            brk_pend     <= 1'b0;
            scan_code    <= '0;
            code_ext     <= 1'b0;
            code_break   <= 1'b0;
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            error        <= 1'b0;
            sft_l        <= 1'b0;
            sft_r        <= 1'b0;
            ctr_l        <= 1'b0;
            ctr_r        <= 1'b0;
            alt_l        <= 1'b0;
            alt_r        <= 1'b0;
            caps_on      <= 1'b0;
            num_on       <= 1'b0;
        end else begin
            key_pressed  <= 1'b0;                    // Strobes by default
            key_released <= 1'b0;
            if (frame_err)
                error <= 1'b1;                       // Sticky until next good frame
            if (frame_valid) begin
                error <= 1'b0;
                if (frame_byte == SC_EXTEND) begin
                    ext_pend <= 1'b1;
                end else if (frame_byte == SC_BREAK) begin
                    brk_pend <= 1'b1;
                end else begin
                    // Code and its prefixes latched together
                    scan_code    <= frame_byte;
                    code_ext     <= ext_pend;
                    code_break   <= brk_pend;
                    key_pressed  <= is_make;
                    key_released <= !is_make;
                    ext_pend     <= 1'b0;
                    brk_pend     <= 1'b0;
                    case (frame_byte)
                        SC_LSHIFT: if (!ext_pend) sft_l <= is_make;
                        SC_RSHIFT: if (!ext_pend) sft_r <= is_make;
                        SC_CTRL: begin
                            if (ext_pend) ctr_r <= is_make;  // E0 14 right Ctrl
                            else          ctr_l <= is_make;
                        end
                        SC_ALT: begin
                            if (ext_pend) alt_r <= is_make;  // E0 11 right Alt
                            else          alt_l <= is_make;
                        end
                        SC_CAPS:   if (is_make && !ext_pend) caps_on   <= !caps_on;
                        SC_NUM:    if (is_make && !ext_pend) num_on    <= !num_on;
                        default: ;
                    endcase
                end
            end
        end
    end

    assign sft_active = sft_l || sft_r;
    assign ctr_active = ctr_l || ctr_r;
    assign alt_active = alt_l || alt_r;

    // Levels to the ASCII map
    assign key.code       = scan_code;
    assign key.code_ext   = code_ext;
    assign key.code_break = code_break;
    assign key.shift_on   = sft_active;
    assign key.ctrl_on    = ctr_active;
    assign key.caps_on    = caps_on;
    assign key.num_on     = num_on;

endmodule

// File: hw/ps2_ascii_map.sv
`timescale 1ns/1ps

module ps2_ascii_map (
    ps2_key_if.map key
);

    logic upper;   // Letter case after Caps Lock

    assign upper = key.shift_on ^ key.caps_on;

    // Letter from its lowercase code, Ctrl gives position 1 to 26
    function automatic logic [7:0] letter(input logic [7:0] lc, input logic ctrl,
                                          input logic up);
        if (ctrl)
            return lc - 8'h60;
        return up ? lc - 8'h20 : lc;
    endfunction

    // Key with a Ctrl code and a Shift pair
    function automatic logic [7:0] ctl_sym(input logic [7:0] cc, input logic [7:0] sh,
                                           input logic [7:0] pl, input logic ctrl,
                                           input logic shift);
        if (ctrl)
            return cc;
        return shift ? sh : pl;
    endfunction

    always_comb begin
        key.ascii = 8'h00;                            // F keys, arrows etc.
        if (!key.code_break && !key.code_ext) begin
            case (key.code)
                // Digit row
                8'h16: key.ascii = key.shift_on ? 8'h21 : 8'h31;  // ! 1
                8'h1E: key.ascii = key.shift_on ? 8'h40 : 8'h32;  // @ 2
                8'h26: key.ascii = key.shift_on ? 8'h23 : 8'h33;  // # 3
                8'h25: key.ascii = key.shift_on ? 8'h24 : 8'h34;  // $ 4
                8'h2E: key.ascii = key.shift_on ? 8'h25 : 8'h35;  // % 5
                8'h36: key.ascii = ctl_sym(8'h1E, 8'h5E, 8'h36, key.ctrl_on, key.shift_on);
                8'h3D: key.ascii = key.shift_on ? 8'h26 : 8'h37;  // & 7
                8'h3E: key.ascii = key.shift_on ? 8'h2A : 8'h38;  // * 8
                8'h46: key.ascii = key.shift_on ? 8'h28 : 8'h39;  // ( 9
                8'h45: key.ascii = key.shift_on ? 8'h29 : 8'h30;  // ) 0
                // Symbols
                8'h0E: key.ascii = key.shift_on ? 8'h7E : 8'h60;  // ~ `
                8'h4E: key.ascii = ctl_sym(8'h1F, 8'h5F, 8'h2D, key.ctrl_on, key.shift_on);
                8'h55: key.ascii = key.shift_on ? 8'h2B : 8'h3D;  // + =
                8'h54: key.ascii = ctl_sym(8'h1B, 8'h7B, 8'h5B, key.ctrl_on, key.shift_on);
                8'h5B: key.ascii = ctl_sym(8'h1D, 8'h7D, 8'h5D, key.ctrl_on, key.shift_on);
                8'h5D: key.ascii = ctl_sym(8'h1C, 8'h7C, 8'h5C, key.ctrl_on, key.shift_on);
                8'h4C: key.ascii = key.shift_on ? 8'h3A : 8'h3B;  // : ;
                8'h52: key.ascii = key.shift_on ? 8'h22 : 8'h27;  // " '
                8'h41: key.ascii = key.shift_on ? 8'h3C : 8'h2C;  // < ,
                8'h49: key.ascii = key.shift_on ? 8'h3E : 8'h2E;  // > .
                8'h4A: key.ascii = ctl_sym(8'h7F, 8'h3F, 8'h2F, key.ctrl_on, key.shift_on);
                // Letters
                8'h1C: key.ascii = letter(8'h61, key.ctrl_on, upper);  // a
                8'h32: key.ascii = letter(8'h62, key.ctrl_on, upper);
                8'h21: key.ascii = letter(8'h63, key.ctrl_on, upper);
                8'h23: key.ascii = letter(8'h64, key.ctrl_on, upper);
                8'h24: key.ascii = letter(8'h65, key.ctrl_on, upper);  // e
                8'h2B: key.ascii = letter(8'h66, key.ctrl_on, upper);
                8'h34: key.ascii = letter(8'h67, key.ctrl_on, upper);
                8'h33: key.ascii = letter(8'h68, key.ctrl_on, upper);
                8'h43: key.ascii = letter(8'h69, key.ctrl_on, upper);  // i
                8'h3B: key.ascii = letter(8'h6A, key.ctrl_on, upper);
                8'h42: key.ascii = letter(8'h6B, key.ctrl_on, upper);
                8'h4B: key.ascii = letter(8'h6C, key.ctrl_on, upper);
                8'h3A: key.ascii = letter(8'h6D, key.ctrl_on, upper);  // m
                8'h31: key.ascii = letter(8'h6E, key.ctrl_on, upper);
                8'h44: key.ascii = letter(8'h6F, key.ctrl_on, upper);
                8'h4D: key.ascii = letter(8'h70, key.ctrl_on, upper);
                8'h15: key.ascii = letter(8'h71, key.ctrl_on, upper);  // q
                8'h2D: key.ascii = letter(8'h72, key.ctrl_on, upper);
                8'h1B: key.ascii = letter(8'h73, key.ctrl_on, upper);
                8'h2C: key.ascii = letter(8'h74, key.ctrl_on, upper);
                8'h3C: key.ascii = letter(8'h75, key.ctrl_on, upper);  // u
                8'h2A: key.ascii = letter(8'h76, key.ctrl_on, upper);
                8'h1D: key.ascii = letter(8'h77, key.ctrl_on, upper);
                8'h22: key.ascii = letter(8'h78, key.ctrl_on, upper);
                8'h35: key.ascii = letter(8'h79, key.ctrl_on, upper);
                8'h1A: key.ascii = letter(8'h7A, key.ctrl_on, upper);  // z
                // Whitespace and editing
                8'h29: key.ascii = 8'h20;   // Space
                8'h66: key.ascii = 8'h08;   // Backspace
                8'h5A: key.ascii = 8'h0D;   // Enter
                8'h76: key.ascii = 8'h1B;   // Escape
                8'h0D: key.ascii = 8'h09;   // Tab
                // Keypad digits only with Num Lock
                8'h70: key.ascii = key.num_on ? 8'h30 : 8'h00;
                8'h69: key.ascii = key.num_on ? 8'h31 : 8'h00;
                8'h72: key.ascii = key.num_on ? 8'h32 : 8'h00;
                8'h7A: key.ascii = key.num_on ? 8'h33 : 8'h00;
                8'h6B: key.ascii = key.num_on ? 8'h34 : 8'h00;
                8'h73: key.ascii = key.num_on ? 8'h35 : 8'h00;
                8'h74: key.ascii = key.num_on ? 8'h36 : 8'h00;
                8'h6C: key.ascii = key.num_on ? 8'h37 : 8'h00;
                8'h75: key.ascii = key.num_on ? 8'h38 : 8'h00;
                8'h7D: key.ascii = key.num_on ? 8'h39 : 8'h00;
                // Keypad operators
                8'h7C: key.ascii = 8'h2A;   // *
                8'h7B: key.ascii = 8'h2D;   // -
                8'h79: key.ascii = 8'h2B;   // +
                8'h71: key.ascii = 8'h2E;   // Point
                default: ;
            endcase
        end else if (!key.code_break) begin
            // E0 codes, the rest are navigation keys with no ASCII
            case (key.code)
                8'h71: key.ascii = 8'h7F;   // Delete
                8'h4A: key.ascii = 8'h2F;   // Keypad /
                8'h5A: key.ascii = 8'h0D;   // Keypad Enter
                default: ;
            endcase
        end
    end

endmodule

// File: hw/ps2_keyboard.sv
`timescale 1ns/1ps

module ps2_keyboard (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] scan_code,
    output logic [7:0] ascii_code,
    output logic       key_pressed,
    output logic       key_released,
    output logic       error,
    output logic       sft_active,
    output logic       alt_active,
    output logic       ctr_active
);

    logic       frame_valid;   // Good frame pulse
    logic       frame_err;     // Bad start, stop or parity
    logic [7:0] frame_byte;

    ps2_key_if key_bus ();

    // Serial frame in, byte out
    ps2_frame_rx u_frame_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .frame_valid (frame_valid),
        .frame_err   (frame_err),
        .frame_byte  (frame_byte)
    );

    ps2_key_tracker u_key_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_valid  (frame_valid),
        .frame_err    (frame_err),
        .frame_byte   (frame_byte),
        .key          (key_bus.tracker),
        .scan_code    (scan_code),
        .key_pressed  (key_pressed),
        .key_released (key_released),
        .error        (error),
        .sft_active   (sft_active),
        .ctr_active   (ctr_active),
        .alt_active   (alt_active)
    );

    // Pure lookup on the held code
    ps2_ascii_map u_ascii_map (
        .key (key_bus.map)
    );

    assign ascii_code = key_bus.ascii;

endmodule

// File: bench/ps2_keyboard_properties.sv
`timescale 1ns/1ps

// Protocol checks on the keyboard top level, bound from the testbench
module ps2_keyboard_properties (
    input logic clk,
    input logic rst_n,
    input logic key_pressed,
    input logic key_released,
    input logic error
);

    int unsigned fail_cnt = 0;   // Read by the testbench at the end

    // One key event per cycle at most
    a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(key_pressed && key_released))
        else begin
            $error("key_pressed and key_released high in the same cycle");
            fail_cnt++;
        end

    // Reset holds both strobes low
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !(key_pressed || key_released))
        else begin
            $error("key strobe while rst_n is low");
            fail_cnt++;
        end

    a_single_press: assert property (@(posedge clk) disable iff (!rst_n)
        key_pressed |=> !key_pressed)
        else begin
            $error("key_pressed high for two cycles in a row");
            fail_cnt++;
        end

    // Bad frame never delivers a key
    a_error_alone: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(error) |-> !(key_pressed || key_released))
        else begin
            $error("error rose together with a key strobe");
            fail_cnt++;
        end

endmodule

// File: bench/ps2_keyboard_tb.sv
`timescale 1ns/1ps

module ps2_keyboard_tb;

    localparam int HALF_BIT   = 20;               // clk cycles per PS/2 half bit
    localparam int FRAME_LEN  = 11;
    localparam int GAP        = 30;               // Idle cycles between frames
    localparam int STROBE_TMO = 3000;
    localparam int STALL_WAIT = (1 << 17) + 200;  // Past the receiver stall limit
    // Set 2 letter codes, z in the top byte, a in the low byte
    localparam logic [207:0] LETTERS = {
        8'h1A, 8'h35, 8'h22, 8'h1D, 8'h2A, 8'h3C, 8'h2C, 8'h1B, 8'h2D, 8'h15, 8'h4D, 8'h44,
        8'h31, 8'h3A, 8'h4B, 8'h42, 8'h3B, 8'h43, 8'h33, 8'h34, 8'h2B, 8'h24, 8'h23, 8'h21,
        8'h32, 8'h1C};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        ps2_clk;
    logic        ps2_data;
    logic [7:0]  scan_code;
    logic [7:0]  ascii_code;
    logic        key_pressed;
    logic        key_released;
    logic        error;
    logic        sft_active;
    logic        alt_active;
    logic        ctr_active;
    int unsigned press_cnt = 0;     // Strobes seen so far
    int unsigned release_cnt = 0;
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned tests = 0;
    int unsigned test_base = 0;     // errors at start of current test
    bit          shift_m;           // Expected modifier and lock state
    bit          ctrl_m;
    bit          alt_m;
    bit          caps_m;
    bit          num_m;

    ps2_keyboard u_ps2_keyboard (
        .clk          (clk),
        .rst_n        (rst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .scan_code    (scan_code),
        .ascii_code   (ascii_code),
        .key_pressed  (key_pressed),
        .key_released (key_released),
        .error        (error),
        .sft_active   (sft_active),
        .alt_active   (alt_active),
        .ctr_active   (ctr_active)
    );

    bind ps2_keyboard ps2_keyboard_properties u_properties (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_pressed  (key_pressed),
        .key_released (key_released),
        .error        (error)
    );

    always #5 clk = ~clk;   // 100 MHz

    // Strobe counters, visible one cycle after the strobe
    always @(posedge clk) begin
        if (key_pressed)
            press_cnt <= press_cnt + 1;
        if (key_released)
            release_cnt <= release_cnt + 1;
    end

    // Expected ASCII for the keys this bench sends
    function automatic logic [7:0] ref_ascii(input logic [7:0] code, input bit ext,
                                             input bit shift, input bit ctrl,
                                             input bit caps, input bit num);
        logic [7:0] res;
        res = 8'h00;                                   // Anything unlisted
        if (ext) begin
            case (code)
                8'h4A: res = 8'h2F;                    // Keypad slash
                8'h5A: res = 8'h0D;
                8'h71: res = 8'h7F;                    // Delete
                default: res = 8'h00;
            endcase
        end else begin
            for (int i = 0; i < 26; i++) begin
                if (LETTERS[8'(i * 8) +: 8] == code)
                    res = ctrl ? 8'(i + 1) : ((shift ^ caps) ? 8'(65 + i) : 8'(97 + i));
            end
            if (code == 8'h16)
                res = shift ? 8'h21 : 8'h31;           // ! or 1
            if (code == 8'h1E)
                res = shift ? 8'h40 : 8'h32;
            if (code == 8'h69)
                res = num ? 8'h31 : 8'h00;             // Keypad 1 needs Num Lock
        end
        return res;
    endfunction

    function automatic logic [7:0] pick_letter();
        int unsigned idx;
        idx = $urandom_range(25);
        return LETTERS[8'(idx * 8) +: 8];
    endfunction

    task automatic check_eq(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        assert (got == exp)
        else begin
            $display("[ERROR] %0t %s is %02h, expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    // LSB first, data changes while ps2_clk is high
    task automatic send_frame(input logic [10:0] frame, input int nbits);
        for (int i = 0; i < nbits; i++) begin
            @(posedge clk);
            ps2_data <= frame[i];
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b0;                           // Receiver samples here
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        @(posedge clk);
        ps2_data <= 1'b1;
        repeat (GAP) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b, input bit bad_par);
        logic par;
        par = ~^b ^ bad_par;                           // Odd parity unless forced wrong
        send_frame({1'b1, par, b, 1'b0}, FRAME_LEN);
    endtask

    // Strobe wait, then port checks against the model
    task automatic expect_key(input bit rel, input logic [7:0] code, input logic [7:0] exp,
                              input int unsigned start);
        int n;
        n = 0;
        while ((rel ? release_cnt : press_cnt) == start && n < STROBE_TMO) begin
            @(posedge clk);
            n++;
        end
        if ((rel ? release_cnt : press_cnt) == start) begin
            $display("Timeout: %s never came for code %02h",
                     rel ? "key_released" : "key_pressed", code);
            errors++;
        end else begin
            check_eq(scan_code, code, "scan_code");
            check_eq(ascii_code, exp, "ascii_code");
            check_eq({7'd0, sft_active}, {7'd0, shift_m}, "sft_active");
            check_eq({7'd0, ctr_active}, {7'd0, ctrl_m}, "ctr_active");
            check_eq({7'd0, alt_active}, {7'd0, alt_m}, "alt_active");
            check_eq({7'd0, error}, 8'd0, "error");
        end
    endtask

    task automatic press_key(input logic [7:0] code, input bit ext);
        int unsigned start;
        logic [7:0]  exp;
        start = press_cnt;
        exp   = ref_ascii(code, ext, shift_m, ctrl_m, caps_m, num_m);
        if (ext)
            send_byte(8'hE0, 1'b0);
        send_byte(code, 1'b0);
        expect_key(1'b0, code, exp, start);
    endtask

    task automatic release_key(input logic [7:0] code, input bit ext);
        int unsigned start;
        start = release_cnt;
        if (ext)
            send_byte(8'hE0, 1'b0);
        send_byte(8'hF0, 1'b0);
        send_byte(code, 1'b0);
        expect_key(1'b1, code, 8'h00, start);          // Break never maps
    endtask

    task automatic wait_error_high();
        int n;
        n = 0;
        while (!error && n < STROBE_TMO) begin
            @(posedge clk);
            n++;
        end
        if (!error) begin
            $display("Timeout: error never went high after a bad parity frame");
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %0d %s: %s", tests, name, (errors == test_base) ? "ok" : "FAILED");
        test_base = errors;
    endtask

    initial begin
        logic [7:0]  code;
        int unsigned start_p;
        int unsigned start_r;
        void'($urandom(12625));
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;                               // Idle lines
        ps2_data = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (10) @(posedge clk);

        code = pick_letter();
        press_key(code, 1'b0);
        release_key(code, 1'b0);
        finish_test("plain make and break");

        shift_m = 1'b1;
        press_key(8'h12, 1'b0);                        // Left Shift held
        press_key(pick_letter(), 1'b0);
        press_key(8'h16, 1'b0);
        press_key(8'h1E, 1'b0);
        shift_m = 1'b0;
        release_key(8'h12, 1'b0);
        caps_m = 1'b1;
        press_key(8'h58, 1'b0);
        release_key(8'h58, 1'b0);                      // Lock stays on after break
        press_key(pick_letter(), 1'b0);
        press_key(8'h16, 1'b0);                        // Digits ignore Caps
        shift_m = 1'b1;
        press_key(8'h59, 1'b0);                        // Right Shift
        press_key(pick_letter(), 1'b0);
        shift_m = 1'b0;
        release_key(8'h59, 1'b0);
        caps_m = 1'b0;
        press_key(8'h58, 1'b0);
        release_key(8'h58, 1'b0);
        ctrl_m = 1'b1;
        press_key(8'h14, 1'b0);
        press_key(pick_letter(), 1'b0);                // Control code 1 to 26
        ctrl_m = 1'b0;
        release_key(8'h14, 1'b0);
        alt_m = 1'b1;
        press_key(8'h11, 1'b0);
        alt_m = 1'b0;
        release_key(8'h11, 1'b0);
        finish_test("shift, caps lock and ctrl");

        start_p = press_cnt;
        start_r = release_cnt;
        send_byte(8'hE0, 1'b0);                        // Prefix on its own
        check_eq(8'(press_cnt - start_p), 8'd0, "key_pressed count after E0");
        check_eq(8'(release_cnt - start_r), 8'd0, "key_released count after E0");
        ctrl_m = 1'b1;
        send_byte(8'h14, 1'b0);
        expect_key(1'b0, 8'h14, 8'h00, start_p);       // Right Ctrl
        ctrl_m = 1'b0;
        release_key(8'h14, 1'b1);
        press_key(8'h4A, 1'b1);
        press_key(8'h5A, 1'b1);
        press_key(8'h71, 1'b1);
        release_key(8'h71, 1'b1);
        finish_test("extended keys");

        press_key(8'h69, 1'b0);                        // Keypad 1, Num Lock off
        release_key(8'h69, 1'b0);
        num_m = 1'b1;
        press_key(8'h77, 1'b0);
        release_key(8'h77, 1'b0);
        press_key(8'h69, 1'b0);
        finish_test("num lock");

        code    = pick_letter();
        start_p = press_cnt;
        start_r = release_cnt;
        send_byte(code, 1'b1);                         // Parity flipped
        wait_error_high();
        check_eq(8'(press_cnt - start_p), 8'd0, "key_pressed count after bad parity");
        check_eq(8'(release_cnt - start_r), 8'd0, "key_released count after bad parity");
        press_key(code, 1'b0);                         // Good frame clears error
        start_p = press_cnt;
        send_frame({2'b11, pick_letter(), 1'b0}, 5);   // Cut off after 5 bits
        for (int i = 0; i < STALL_WAIT; i++)
            @(posedge clk);
        check_eq(8'(press_cnt - start_p), 8'd0, "key_pressed count after cut frame");
        check_eq({7'd0, error}, 8'd0, "error after cut frame");
        press_key(pick_letter(), 1'b0);                // Receiver realigned
        finish_test("frame errors");

        errors = errors + u_ps2_keyboard.u_properties.fail_cnt;
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: build.f
hw/ps2_pkg.sv
hw/ps2_key_if.sv
hw/ps2_frame_rx.sv
hw/ps2_key_tracker.sv
hw/ps2_ascii_map.sv
hw/ps2_keyboard.sv
bench/ps2_keyboard_properties.sv
bench/ps2_keyboard_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the PS/2 keyboard testbench with Verilator, run it, look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module ps2_keyboard_tb -f build.f -o ps2_keyboard_sim \
    && ./obj_dir/ps2_keyboard_sim | tee /dev/stderr \
        | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
